/* sources.f */
rtl/reflex_bus_pkg.sv
rtl/reflex_model_pkg.sv
rtl/reflex_param_regs.sv
rtl/afferent_stage.sv
rtl/lif_neuron.sv
rtl/spike_window_counter.sv
rtl/stretch_reflex_top.sv
testbench/stretch_reflex_props.sv
testbench/tb_stretch_reflex.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_stretch_reflex \
    -f sources.f -Mdir obj_dir

out=$(./obj_dir/Vtb_stretch_reflex)
echo "$out"

if echo "$out" | grep -q "^No errors$"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* testbench/tb_stretch_reflex.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stretch_reflex;

    localparam int     LEAK_SHIFT = 4;
    localparam int     GAIN_FRAC  = 8;
    localparam longint VAL_MAX    = 64'hFF_FFFF;  // 24 bit drive and membrane

    logic        ep50trig = 1'b0;
    logic        reset_global;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [3:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic        i_len_valid;
    logic [15:0] i_len;
    wire  [31:0] o_wb_dat;
    wire         o_wb_ack;
    wire         o_spike;
    wire         o_step_valid;
    wire  [15:0] o_count;
    wire         o_count_valid;

    // stimulus table, one entry per row
    string  row_name[$];
    int     row_gain[$];
    int     row_rest[$];
    int     row_thr[$];
    int     row_win[$];
    int     row_len[$];       // 0 picks random lengths
    int     row_steps[$];
    int     row_gaps[$];
    int     row_new_win[$];
    int     row_new_at[$];    // step index of a mid-window write, 0 for none

    // register shadow and reference model state
    longint m_gain = 256;
    longint m_rest = 1000;
    longint m_thr = 4000;
    longint m_window = 16;
    longint m_memb = 0;
    longint m_steps = 0;
    longint m_spikes = 0;
    longint m_win_len = 0;
    longint m_last_count = 0;
    bit     m_counting = 1'b0;
    longint exp_count_q[$];
    int     exp_cycle_q[$];
    longint mon_exp;
    int     mon_cyc;

    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    int     errors = 0;
    int     err_at_start = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     seed = 11;
    string  test_name = "reset";
    longint spikes_exp = 0;
    longint spikes_seen = 0;

    stretch_reflex_top #(.LEAK_SHIFT(LEAK_SHIFT), .GAIN_FRAC(GAIN_FRAC)) uut
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_len_valid   (i_len_valid),
        .i_len         (i_len),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_spike       (o_spike),
        .o_step_valid  (o_step_valid),
        .o_count       (o_count),
        .o_count_valid (o_count_valid)
    );

    always #50 ep50trig = ~ep50trig;   // 100 ns period

    always @(posedge ep50trig)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles in test %s", cycle_cnt, test_name);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_value(input string what, input longint exp, input longint act);
        assert (exp == act)
        else
        begin
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge ep50trig)
    begin
        if (!reset_global && o_step_valid && o_spike)
            spikes_seen++;
        if (!reset_global && o_count_valid)
        begin
            assert (exp_count_q.size() > 0)
            else
            begin
                $display("%s: window count %0d emitted with none expected", test_name, o_count);
                errors++;
            end
            if (exp_count_q.size() > 0)
            begin
                mon_exp = exp_count_q.pop_front();
                mon_cyc = exp_cycle_q.pop_front();
                check_value("window count", mon_exp, o_count);
                assert (cycle_cnt == mon_cyc + 3)   // 3 cycles after the last sample
                else
                begin
                    $display("%s: window count came at cycle %0d, not at cycle %0d",
                             test_name, cycle_cnt, mon_cyc + 3);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model of one simulation step
    ////////////////////////////////////////////////////////////

    task automatic model_step(input longint len, input int cyc);
        longint stretch;
        longint drv;
        longint nxt;
        longint win_eff;
        longint cur_len;
        bit     fire;
        stretch = (len > m_rest) ? len - m_rest : 0;
        drv     = (stretch * m_gain) >> GAIN_FRAC;
        if (drv > VAL_MAX)
            drv = VAL_MAX;
        nxt = m_memb - (m_memb >> LEAK_SHIFT) + drv;
        if (nxt > VAL_MAX)
            nxt = VAL_MAX;                   // membrane saturates
        fire        = (nxt >= m_thr);
        m_memb      = fire ? 0 : nxt;
        spikes_exp += fire;
        win_eff     = (m_window == 0) ? 1 : m_window;
        cur_len     = m_counting ? m_win_len : win_eff;
        if (m_steps + 1 == cur_len)
        begin
            m_last_count = m_spikes + fire;
            exp_count_q.push_back(m_last_count);
            exp_cycle_q.push_back(cyc);
            m_steps   = 0;
            m_spikes  = 0;
            m_win_len = win_eff;             // length for the next window
        end
        else
        begin
            m_steps  = m_steps + 1;
            m_spikes = m_spikes + fire;
            if (!m_counting)
                m_win_len = win_eff;
        end
        m_counting = 1'b1;
    endtask

    // one wishbone classic access, also keeps the register shadow
    task automatic bus_access(input bit we, input logic [3:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge ep50trig);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        @(negedge ep50trig);
        while (!o_wb_ack && waited < 16)
        begin
            @(negedge ep50trig);
            waited++;
        end
        assert (o_wb_ack)
        else
        begin
            $display("%s: no ack on address %0d", test_name, adr);
            errors++;
        end
        rdata    = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        @(negedge ep50trig);
        assert (!o_wb_ack)
        else
        begin
            $display("%s: ack on address %0d lasted more than one cycle", test_name, adr);
            errors++;
        end
        if (we)
        begin
            case (adr)
                4'd0: m_gain   = dat[15:0];
                4'd1: m_rest   = dat[15:0];
                4'd2: m_thr    = dat[23:0];
                4'd3: m_window = dat[15:0];
                default: ;                   // read only or unmapped
            endcase
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = errors;
        spikes_exp   = 0;
        spikes_seen  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_at_start)
            tests_failed++;
        $display("%-18s %s", test_name, (errors == err_at_start) ? "ok" : "FAILED");
    endtask

    task automatic write_then_read(input logic [3:0] adr, input logic [31:0] wdata,
                                   input longint exp);
        logic [31:0] rd;
        bus_access(1'b1, adr, wdata, rd);
        bus_access(1'b0, adr, 32'd0, rd);
        check_value($sformatf("address %0d", adr), exp, rd);
    endtask

    task automatic reset_value_test();
        logic [31:0] rd;
        longint      exp;
        start_test("reset_values");
        for (int a = 0; a < 16; a++)
        begin
            bus_access(1'b0, a[3:0], 32'd0, rd);
            exp = (a == 0) ? 256 : (a == 1) ? 1000 : (a == 2) ? 4000 : (a == 3) ? 16 : 0;
            check_value($sformatf("address %0d", a), exp, rd);
        end
        end_test();
    endtask

    task automatic reg_rw_test();
        start_test("register_rw");
        write_then_read(4'd0, 32'hFFFF_1234, 64'h1234);      // only the low 16 bits stick
        write_then_read(4'd1, 32'h0000_BEEF, 64'hBEEF);
        write_then_read(4'd2, 32'h12AB_CDEF, 64'hAB_CDEF);
        write_then_read(4'd3, 32'h0000_0021, 64'h21);
        write_then_read(4'd4, 32'h0000_FFFF, m_last_count);  // count ignores writes
        write_then_read(4'd9, 32'hFFFF_FFFF, 0);
        end_test();
    endtask

    task automatic add_row(input string name, input int gain, rest, thr, win, len, steps,
                           gaps, new_win, new_at);
        row_name.push_back(name);
        row_gain.push_back(gain);
        row_rest.push_back(rest);
        row_thr.push_back(thr);
        row_win.push_back(win);
        row_len.push_back(len);
        row_steps.push_back(steps);
        row_gaps.push_back(gaps);
        row_new_win.push_back(new_win);
        row_new_at.push_back(new_at);
    endtask

    task automatic run_row(input int r);
        logic [31:0] rd;
        int          len;
        int          gap;
        start_test(row_name[r]);
        bus_access(1'b1, 4'd0, row_gain[r], rd);
        bus_access(1'b1, 4'd1, row_rest[r], rd);
        bus_access(1'b1, 4'd2, row_thr[r], rd);
        bus_access(1'b1, 4'd3, row_win[r], rd);
        for (int s = 0; s < row_steps[r]; s++)
        begin
            if (row_new_at[r] != 0 && s == row_new_at[r])
            begin
                @(negedge ep50trig);
                i_len_valid = 1'b0;
                bus_access(1'b1, 4'd3, row_new_win[r], rd);   // lands mid-window
            end
            gap = (row_gaps[r] != 0) ? int'($unsigned($random(seed)) % 3) : 0;
            repeat (gap)
            begin
                @(negedge ep50trig);
                i_len_valid = 1'b0;
            end
            if (row_len[r] != 0)
                len = row_len[r];
            else
                len = row_rest[r] - 600 + int'($unsigned($random(seed)) % 1500);
            @(negedge ep50trig);
            i_len_valid = 1'b1;
            i_len       = len[15:0];
            model_step(len, cycle_cnt);
        end
        @(negedge ep50trig);
        i_len_valid = 1'b0;
        repeat (4) @(negedge ep50trig);    // drain the pipeline
        check_value("spike total", spikes_exp, spikes_seen);
        check_value("pending windows", 0, exp_count_q.size());
        bus_access(1'b0, 4'd4, 32'd0, rd);
        check_value("count register", m_last_count, rd);
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_adr     = 4'd0;
        i_wb_dat     = 32'd0;
        i_len_valid  = 1'b0;
        i_len        = 16'd0;
        //       name                gain    rest  thr        win len     steps gaps nw at
        add_row("at_rest",          'h100,  1000, 4000,      16, 1000,   32,   0,   0, 0);
        add_row("below_rest",       'h300,  2000, 100,       8,  1500,   16,   0,   0, 0);
        add_row("const_stretch",    'h180,  1000, 4000,      16, 1400,   64,   0,   0, 0);
        add_row("const_every_step", 'h400,  500,  3000,      8,  1500,   32,   0,   0, 0);
        add_row("membrane_sat",     'hFFFF, 0,    'hFFFFFF,  4,  'hFFFF, 8,    0,   0, 0);
        add_row("rand_back2back",   'h200,  1000, 5000,      10, 0,      100,  0,   0, 0);
        add_row("rand_gaps",        'h100,  800,  3000,      12, 0,      96,   1,   0, 0);
        add_row("window_mid_write", 'h200,  1000, 2500,      8,  0,      60,   0,   5, 20);
        add_row("zero_window",      'h100,  1000, 1500,      0,  2000,   20,   0,   0, 0);
        foreach (row_steps[i])
            cycle_limit += row_steps[i] * 4 + 200;
        repeat (2) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
        reset_value_test();
        reg_rw_test();
        foreach (row_name[r])
            run_row(r);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/stretch_reflex_props.sv */
`timescale 1ns/1ps
`default_nettype none

module stretch_reflex_props
(
    input wire ep50trig,
    input wire reset_global,
    input wire i_wb_cyc,
    input wire i_wb_stb,
    input wire i_wb_ack,
    input wire i_len_valid,
    input wire i_step_valid
);

    ////////////////////////////////////////////////////////////
    // wishbone handshake
    ////////////////////////////////////////////////////////////

    ack_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_wb_ack |=> !i_wb_ack)
        else $error("wishbone ack high for two cycles in a row");

    ack_after_cycle: assert property (@(posedge ep50trig) disable iff (reset_global)
        $rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
        else $error("wishbone ack without a valid bus cycle before it");

    // afferent plus neuron, two registered stages
    step_latency: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_step_valid == $past(i_len_valid, 2))
        else $error("step valid does not follow the sample valid by two cycles");

endmodule

bind stretch_reflex_top stretch_reflex_props u_props
(
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_ack     (o_wb_ack),
    .i_len_valid  (i_len_valid),
    .i_step_valid (o_step_valid)
);

`default_nettype wire

/* rtl/stretch_reflex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stretch_reflex_top
#(
    parameter int LEAK_SHIFT = 4,
    parameter int GAIN_FRAC  = 8
)
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_wb_cyc,
    input  wire                            i_wb_stb,
    input  wire                            i_wb_we,
    input  wire reflex_bus_pkg::wb_addr_t  i_wb_adr,
    input  wire reflex_bus_pkg::wb_data_t  i_wb_dat,
    input  wire                            i_len_valid,
    input  wire reflex_model_pkg::len_t    i_len,
    output reflex_bus_pkg::wb_data_t       o_wb_dat,
    output wire                            o_wb_ack,
    output wire                            o_spike,
    output wire                            o_step_valid,
    output reflex_model_pkg::count_t       o_count,
    output wire                            o_count_valid
);

    wire [15:0]               gain;
    reflex_model_pkg::len_t   rest_len;
    reflex_model_pkg::memb_t  threshold;
    reflex_model_pkg::count_t window;
    reflex_model_pkg::drive_t drive;
    wire                      drive_valid;

    ////////////////////////////////////////////////////////////
    // host register bank
    ////////////////////////////////////////////////////////////

    reflex_param_regs u_regs
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_count       (o_count),
        .i_count_valid (o_count_valid),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_gain        (gain),
        .o_rest_len    (rest_len),
        .o_threshold   (threshold),
        .o_window      (window)
    );

    ////////////////////////////////////////////////////////////
    // reflex pipeline, length -> drive -> spike -> count
    ////////////////////////////////////////////////////////////

    afferent_stage #(.GAIN_FRAC(GAIN_FRAC)) u_afferent
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_len_valid   (i_len_valid),
        .i_len         (i_len),
        .i_rest_len    (rest_len),
        .i_gain        (gain),
        .o_drive       (drive),
        .o_drive_valid (drive_valid)
    );

    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) u_neuron
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_drive_valid (drive_valid),
        .i_drive       (drive),
        .i_threshold   (threshold),
        .o_step_valid  (o_step_valid),
        .o_spike       (o_spike)
    );

    spike_window_counter u_counter
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_step_valid  (o_step_valid),
        .i_spike       (o_spike),
        .i_window      (window),
        .o_count       (o_count),
        .o_count_valid (o_count_valid)
    );

endmodule

`default_nettype wire

/* rtl/spike_window_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_window_counter
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_step_valid,
    input  wire                            i_spike,
    input  wire reflex_model_pkg::count_t  i_window,
    output reflex_model_pkg::count_t       o_count,
    output logic                           o_count_valid
);

    typedef enum logic {IDLE, COUNTING} win_state_t;

    win_state_t               state;
    reflex_model_pkg::count_t win_len;     // length of the running window
    reflex_model_pkg::count_t cur_len;
    reflex_model_pkg::count_t step_cnt;
    reflex_model_pkg::count_t spike_cnt;
    reflex_model_pkg::count_t step_next;
    reflex_model_pkg::count_t spike_next;
    logic                     win_done;

    // first window has not latched a length yet
    assign cur_len = (state == IDLE) ? i_window : win_len;

    assign step_next  = step_cnt + 16'd1;
    assign spike_next = spike_cnt + {15'd0, i_spike};
    assign win_done   = i_step_valid && (step_next == cur_len);

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state         <= IDLE;
            win_len       <= '0;
            step_cnt      <= '0;
            spike_cnt     <= '0;
            o_count_valid <= 1'b0;
        end
        else
        begin
            o_count_valid <= win_done;
            if (i_step_valid)
            begin
                state <= COUNTING;
                if (win_done)
                begin
                    step_cnt  <= '0;
                    spike_cnt <= '0;
                    win_len   <= i_window;       // next window length
                end
                else
                begin
                    step_cnt  <= step_next;
                    spike_cnt <= spike_next;
                    if (state == IDLE)
                        win_len <= i_window;
                end
            end
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (win_done)
            o_count <= spike_next;
    end

endmodule

`default_nettype wire

/* rtl/lif_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module lif_neuron
#(
    parameter int LEAK_SHIFT = 4    // leak of memb / 2^LEAK_SHIFT per step
)
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_drive_valid,
    input  wire reflex_model_pkg::drive_t  i_drive,
    input  wire reflex_model_pkg::memb_t   i_threshold,
    output logic                           o_step_valid,
    output logic                           o_spike
);

    localparam int MEMB_W = $bits(reflex_model_pkg::memb_t);

    reflex_model_pkg::memb_t memb;
    reflex_model_pkg::memb_t leaked;
    logic [MEMB_W:0]         sum;          // one carry bit for saturation
    reflex_model_pkg::memb_t memb_next;
    logic                    fire;

    ////////////////////////////////////////////////////////////
    // membrane update
    ////////////////////////////////////////////////////////////

    assign leaked = memb - (memb >> LEAK_SHIFT);   // cannot underflow
    assign sum    = {1'b0, leaked} + {1'b0, i_drive};

    assign memb_next = sum[MEMB_W] ? {MEMB_W{1'b1}} : sum[MEMB_W-1:0];
    assign fire      = (memb_next >= i_threshold);

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            memb         <= '0;
            o_step_valid <= 1'b0;
            o_spike      <= 1'b0;
        end
        else
        begin
            o_step_valid <= i_drive_valid;
            o_spike      <= i_drive_valid && fire;
            if (i_drive_valid)
                memb <= fire ? '0 : memb_next;   // reset to zero on a spike
        end
    end

endmodule

`default_nettype wire

/* rtl/afferent_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module afferent_stage
#(
    parameter int GAIN_FRAC = 8     // fraction bits of the gain
)
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_len_valid,
    input  wire reflex_model_pkg::len_t    i_len,
    input  wire reflex_model_pkg::len_t    i_rest_len,
    input  wire [15:0]                     i_gain,
    output reflex_model_pkg::drive_t       o_drive,
    output logic                           o_drive_valid
);

    localparam int DRIVE_W = $bits(reflex_model_pkg::drive_t);

    reflex_model_pkg::len_t stretch;
    logic [31:0]            product;
    logic [31:0]            scaled;
    reflex_model_pkg::drive_t drive_sat;

    // only lengthening past rest excites the afferent
    assign stretch = (i_len > i_rest_len) ? i_len - i_rest_len : '0;

    assign product = stretch * i_gain;
    assign scaled  = product >> GAIN_FRAC;     // floor of the fixed point product

    assign drive_sat = (|scaled[31:DRIVE_W]) ? {DRIVE_W{1'b1}} : scaled[DRIVE_W-1:0];

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_drive_valid <= 1'b0;
        else
            o_drive_valid <= i_len_valid;
    end

    always_ff @(posedge ep50trig)
    begin
        if (i_len_valid)
            o_drive <= drive_sat;
    end

endmodule

`default_nettype wire

/* rtl/reflex_param_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module reflex_param_regs
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire                            i_wb_cyc,
    input  wire                            i_wb_stb,
    input  wire                            i_wb_we,
    input  wire reflex_bus_pkg::wb_addr_t  i_wb_adr,
    input  wire reflex_bus_pkg::wb_data_t  i_wb_dat,
    input  wire reflex_model_pkg::count_t  i_count,
    input  wire                            i_count_valid,
    output reflex_bus_pkg::wb_data_t       o_wb_dat,
    output logic                           o_wb_ack,
    output logic [15:0]                    o_gain,
    output reflex_model_pkg::len_t         o_rest_len,
    output reflex_model_pkg::memb_t        o_threshold,
    output reflex_model_pkg::count_t       o_window
);

    reflex_model_pkg::count_t window_q;     // as written by the host
    reflex_model_pkg::count_t count_q;      // last emitted window count
    reflex_model_pkg::count_t count_view;
    logic                     access;

    // one access per two cycles, ack gap blocks a second hit
    assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // fresh count is visible as soon as the counter strobes it
    assign count_view = i_count_valid ? i_count : count_q;

    assign o_window = (window_q == '0) ? reflex_model_pkg::MIN_WINDOW : window_q;

    ////////////////////////////////////////////////////////////
    // control and coefficient registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_wb_ack    <= 1'b0;
            o_gain      <= reflex_model_pkg::RST_GAIN;
            o_rest_len  <= reflex_model_pkg::RST_REST_LEN;
            o_threshold <= reflex_model_pkg::RST_THRESHOLD;
            window_q    <= reflex_model_pkg::RST_WINDOW;
            count_q     <= '0;
        end
        else
        begin
            o_wb_ack <= access;
            if (i_count_valid)
                count_q <= i_count;
            if (access && i_wb_we)
            begin
                case (i_wb_adr)
                    reflex_bus_pkg::ADDR_GAIN:      o_gain      <= i_wb_dat[15:0];
                    reflex_bus_pkg::ADDR_REST_LEN:  o_rest_len  <= i_wb_dat[15:0];
                    reflex_bus_pkg::ADDR_THRESHOLD: o_threshold <= i_wb_dat[23:0];
                    reflex_bus_pkg::ADDR_WINDOW:    window_q    <= i_wb_dat[15:0];
                    default: ;                      // count and holes ignore writes
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read data mux
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (access)
        begin
            case (i_wb_adr)
                reflex_bus_pkg::ADDR_GAIN:        o_wb_dat <= {16'd0, o_gain};
                reflex_bus_pkg::ADDR_REST_LEN:    o_wb_dat <= {16'd0, o_rest_len};
                reflex_bus_pkg::ADDR_THRESHOLD:   o_wb_dat <= {8'd0, o_threshold};
                reflex_bus_pkg::ADDR_WINDOW:      o_wb_dat <= {16'd0, window_q};
                reflex_bus_pkg::ADDR_SPIKE_COUNT: o_wb_dat <= {16'd0, count_view};
                default:                          o_wb_dat <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/reflex_model_pkg.sv */
`default_nettype none

package reflex_model_pkg;

    ////////////////////////////////////////////////////////////
    // model value types
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] len_t;     // unsigned muscle length
    typedef logic [23:0] drive_t;   // synaptic drive into the neuron
    typedef logic [23:0] memb_t;    // membrane value
    typedef logic [15:0] count_t;   // spikes or steps per window

    ////////////////////////////////////////////////////////////
    // register reset values
    ////////////////////////////////////////////////////////////

    localparam logic [15:0] RST_GAIN      = 16'h0100;   // gain of 1.0
    localparam len_t        RST_REST_LEN  = 16'd1000;
    localparam memb_t       RST_THRESHOLD = 24'd4000;
    localparam count_t      RST_WINDOW    = 16'd16;

    // window of zero is legal in the register but acts as one
    localparam count_t      MIN_WINDOW    = 16'd1;

endpackage

`default_nettype wire

/* rtl/reflex_bus_pkg.sv */
`default_nettype none

package reflex_bus_pkg;

    ////////////////////////////////////////////////////////////
    // host port word types
    ////////////////////////////////////////////////////////////

    typedef logic [3:0]  wb_addr_t;   // register word address
    typedef logic [31:0] wb_data_t;   // bus data word

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    localparam wb_addr_t ADDR_GAIN        = 4'd0;  // q8.8 afferent gain
    localparam wb_addr_t ADDR_REST_LEN    = 4'd1;
    localparam wb_addr_t ADDR_THRESHOLD   = 4'd2;
    localparam wb_addr_t ADDR_WINDOW      = 4'd3;  // window length in steps
    localparam wb_addr_t ADDR_SPIKE_COUNT = 4'd4;  // read only

    // 5 to 15 are unmapped and read back as zero

endpackage

`default_nettype wire
